//--- Makefile
# Verilator build for the memory control unit testbench

VERILATOR ?= verilator
TOP       ?= tb_mcu
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
mcu_pkg.sv
mcu_cfg_decode.sv
mcu_store_ctrl.sv
mcu_load_ctrl.sv
mcu_top.sv
tb_mcu.sv

//--- mcu_cfg_decode.sv
// EMUL lookup for unit-stride accesses.
// Maps a request's SEW, LMUL and memory width onto the data SEW and data LMUL.

`default_nettype none

module mcu_cfg_decode (
  input  mcu_pkg::vtype_t   vtype_i,
  output mcu_pkg::mem_cfg_t cfg_o
);

  // Entry holds the data LMUL code, 0 for unsupported combinations
  function automatic logic [127:0][2:0] build_emul_tbl();
    logic [127:0][2:0] tbl;
    logic [1:0]        w_code;
    logic [2:0]        l_code;
    logic [1:0]        s_code;
    int                l_log2;
    int                res;
    for (int idx = 0; idx < 128; idx++) begin
      w_code = idx[6:5];
      l_code = idx[4:2];
      s_code = idx[1:0];
      // Fractional codes 5..7 stand for -3..-1
      l_log2 = (l_code > 3'd4) ? int'(l_code) - 8 : int'(l_code);
      res    = l_log2 + int'(w_code) - int'(s_code);
      if (s_code == 2'd3 || l_code == 3'd4 || res < -3 || res > 3) begin
        tbl[idx] = 3'd0;
      end else begin
        tbl[idx] = 3'(res);
      end
    end
    return tbl;
  endfunction

  localparam logic [127:0][2:0] EMUL_TBL = build_emul_tbl();

  logic [6:0] tbl_addr;

  // Index is width, lmul, sew from high to low
  assign tbl_addr = {vtype_i.mem_width[1:0], vtype_i.lmul, vtype_i.sew[1:0]};

  always_comb begin
    cfg_o.data_sew  = vtype_i.mem_width;
    cfg_o.data_lmul = EMUL_TBL[tbl_addr];
  end

endmodule

`default_nettype wire

//--- mcu_load_ctrl.sv
// Unit-stride load sequencer.
// Fills the load buffer from the memory master, then drains it to the vector lane.

`default_nettype none

module mcu_load_ctrl #(
  parameter integer BUFF_RD_LAT = mcu_pkg::BUFF_RD_LAT_DEF
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  mcu_ld_vld_i,
  input  mcu_pkg::mem_cfg_t     dec_cfg_i,
  output logic                  mcu_ld_rdy_o,
  output logic                  mcu_ld_buffered_o,
  output mcu_pkg::mem_cfg_t     load_cfg_o,
  output logic                  load_cfg_update_o,
  output logic                  load_cntr_rst_o,
  output mcu_pkg::buff_ctrl_t   ldbuff_ctrl_o,
  output logic                  ldbuff_flush_o,
  input  mcu_pkg::buff_status_t ldbuff_status_i,
  output logic                  ctrl_rstart_o,
  input  logic                  rd_tvalid_i,
  input  logic                  rd_tlast_i,
  output logic                  rd_tready_o,
  input  logic                  vlane_load_rdy_i,
  output logic                  vlane_load_dvalid_o,
  output logic                  vlane_load_last_o
);

  // Only the oldest stage still holds a beat
  localparam logic [BUFF_RD_LAT:0] DLY_LAST = {1'b1, {BUFF_RD_LAT{1'b0}}};

  mcu_pkg::load_state_e state_q, state_d;
  mcu_pkg::mem_cfg_t    cfg_q;
  logic                 ld_vld_q;
  logic                 cfg_save;
  logic                 rstart_lvl;
  logic                 rstart_q;
  logic                 lane_vld_push;
  logic [BUFF_RD_LAT:0] lane_vld_dly;

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q  <= mcu_pkg::ld_idle;
      ld_vld_q <= 1'b0;
      rstart_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      ld_vld_q <= mcu_ld_vld_i;
      rstart_q <= rstart_lvl;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cfg_q <= '0;
    end else if (cfg_save) begin
      cfg_q <= dec_cfg_i;
    end
  end

  assign load_cfg_o = cfg_q;

  // Rising edge of the fill level starts the read burst
  assign ctrl_rstart_o = rstart_lvl && !rstart_q;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lane_vld_dly <= '0;
    end else if (!ldbuff_ctrl_o.read_stall) begin
      lane_vld_dly <= {lane_vld_dly[BUFF_RD_LAT-1:0], lane_vld_push};
    end
  end

  assign vlane_load_dvalid_o = ldbuff_status_i.read_done ? lane_vld_dly[BUFF_RD_LAT]
                                                         : lane_vld_dly[BUFF_RD_LAT-1];
  assign vlane_load_last_o   = (lane_vld_dly == DLY_LAST);
  assign ldbuff_flush_o      = (lane_vld_dly == '0);

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d           = state_q;
    cfg_save          = 1'b0;
    mcu_ld_rdy_o      = 1'b0;
    mcu_ld_buffered_o = 1'b0;
    load_cfg_update_o = 1'b0;
    load_cntr_rst_o   = 1'b0;
    ldbuff_ctrl_o     = '0;
    rstart_lvl        = 1'b0;
    rd_tready_o       = 1'b0;
    lane_vld_push     = 1'b0;

    case (state_q)
      mcu_pkg::ld_idle: begin
        mcu_ld_rdy_o = 1'b1;
        if (ld_vld_q) begin
          mcu_ld_rdy_o      = 1'b0;
          load_cfg_update_o = 1'b1;
          load_cntr_rst_o   = 1'b1;
          state_d           = mcu_pkg::ld_fill;
        end else if (mcu_ld_vld_i) begin
          cfg_save = 1'b1;
        end
      end

      mcu_pkg::ld_fill: begin
        rstart_lvl        = 1'b1;
        rd_tready_o       = 1'b1;
        ldbuff_ctrl_o.wen = rd_tvalid_i;
        if (rd_tlast_i) begin
          // Burst complete, pre-read the first beat
          mcu_ld_buffered_o = 1'b1;
          ldbuff_ctrl_o.ren = 1'b1;
          lane_vld_push     = 1'b1;
          state_d           = mcu_pkg::ld_drain;
        end
      end

      mcu_pkg::ld_drain: begin
        ldbuff_ctrl_o.ren = 1'b1;
        lane_vld_push     = 1'b1;
        if (ldbuff_status_i.read_done && vlane_load_rdy_i) begin
          ldbuff_ctrl_o.ren = 1'b0;
          lane_vld_push     = 1'b0;
          if (vlane_load_last_o) begin
            state_d = mcu_pkg::ld_idle;
          end
        end
        if (!vlane_load_rdy_i) begin
          ldbuff_ctrl_o.read_stall = 1'b1;
          ldbuff_ctrl_o.ren        = 1'b0;
        end
      end

      default: state_d = mcu_pkg::ld_idle;
    endcase
  end

endmodule

`default_nettype wire

//--- mcu_pkg.sv
// Shared types for the vector memory control unit.
// Compiled first; other files refer to it by scoped names.

`default_nettype none

package mcu_pkg;

  ////////////////////
  // Configuration
  ////////////////////

  // Vector configuration of a request as issued by the scheduler
  typedef struct packed {
    logic [2:0] sew;
    logic [2:0] lmul;
    logic [2:0] mem_width;
  } vtype_t;

  // Decoded configuration held for one transfer
  typedef struct packed {
    logic [2:0] data_sew;
    logic [2:0] data_lmul;
  } mem_cfg_t;

  ////////////////////
  // Data buffers
  ////////////////////

  // Controls toward one data buffer
  typedef struct packed {
    logic wen;
    logic ren;
    logic read_stall;
  } buff_ctrl_t;

  // Status reported back by a data buffer
  typedef struct packed {
    logic not_empty;
    logic write_done;
    logic read_done;
  } buff_status_t;

  // Cycles from read enable to data at the buffer output
  localparam integer BUFF_RD_LAT_DEF = 2;

  ////////////////////
  // FSM states
  ////////////////////

  typedef enum logic [1:0] {
    st_idle,
    st_fill,
    st_drain
  } store_state_e;

  typedef enum logic [1:0] {
    ld_idle,
    ld_fill,
    ld_drain
  } load_state_e;

endpackage

`default_nettype wire

//--- mcu_store_ctrl.sv
// Unit-stride store sequencer.
// Fills the store buffer from the vector lane, then drains it to the memory master.

`default_nettype none

module mcu_store_ctrl #(
  parameter integer BUFF_RD_LAT = mcu_pkg::BUFF_RD_LAT_DEF
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  mcu_st_vld_i,
  input  mcu_pkg::mem_cfg_t     dec_cfg_i,
  output logic                  mcu_st_rdy_o,
  output mcu_pkg::mem_cfg_t     store_cfg_o,
  output logic                  store_cfg_update_o,
  output logic                  store_cntr_rst_o,
  output mcu_pkg::buff_ctrl_t   sbuff_ctrl_o,
  input  mcu_pkg::buff_status_t sbuff_status_i,
  input  logic                  vlane_store_dvalid_i,
  output logic                  vlane_store_rdy_o,
  output logic                  ctrl_wstart_o,
  input  logic                  ctrl_wdone_i,
  input  logic                  wr_tready_i,
  output logic                  wr_tvalid_o
);

  mcu_pkg::store_state_e state_q, state_d;
  mcu_pkg::mem_cfg_t     cfg_q;
  logic                  st_vld_q;
  logic                  cfg_save;
  logic                  wr_tvalid_push;
  logic [BUFF_RD_LAT:0]  wr_tvalid_dly;

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q  <= mcu_pkg::st_idle;
      st_vld_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      st_vld_q <= mcu_st_vld_i;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cfg_q <= '0;
    end else if (cfg_save) begin
      cfg_q <= dec_cfg_i;
    end
  end

  assign store_cfg_o = cfg_q;

  // Tracks reads in flight through the buffer output pipeline
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_tvalid_dly <= '0;
    end else if (!sbuff_ctrl_o.read_stall) begin
      wr_tvalid_dly <= {wr_tvalid_dly[BUFF_RD_LAT-1:0], wr_tvalid_push};
    end
  end

  // Last read of the buffer lands one stage later
  assign wr_tvalid_o = sbuff_status_i.read_done ? wr_tvalid_dly[BUFF_RD_LAT]
                                                : wr_tvalid_dly[BUFF_RD_LAT-1];

  ////////////////////
  // FSM
  ////////////////////

  always_comb begin
    state_d            = state_q;
    cfg_save           = 1'b0;
    mcu_st_rdy_o       = 1'b0;
    store_cfg_update_o = 1'b0;
    store_cntr_rst_o   = 1'b0;
    sbuff_ctrl_o       = '0;
    vlane_store_rdy_o  = 1'b0;
    ctrl_wstart_o      = 1'b0;
    wr_tvalid_push     = 1'b0;

    case (state_q)
      mcu_pkg::st_idle: begin
        mcu_st_rdy_o = 1'b1;
        if (st_vld_q) begin
          mcu_st_rdy_o       = 1'b0;
          store_cfg_update_o = 1'b1;
          store_cntr_rst_o   = 1'b1;
          state_d            = mcu_pkg::st_fill;
        end else if (mcu_st_vld_i) begin
          cfg_save = 1'b1;
        end
      end

      mcu_pkg::st_fill: begin
        vlane_store_rdy_o = 1'b1;
        sbuff_ctrl_o.wen  = vlane_store_dvalid_i;
        if (sbuff_status_i.write_done && vlane_store_dvalid_i) begin
          // Kick off the write and pre-read the first beat
          ctrl_wstart_o    = 1'b1;
          sbuff_ctrl_o.ren = 1'b1;
          wr_tvalid_push   = 1'b1;
          state_d          = mcu_pkg::st_drain;
        end
      end

      mcu_pkg::st_drain: begin
        sbuff_ctrl_o.ren = 1'b1;
        wr_tvalid_push   = 1'b1;
        if (sbuff_status_i.read_done && wr_tready_i) begin
          sbuff_ctrl_o.ren = 1'b0;
          wr_tvalid_push   = 1'b0;
        end
        if (!wr_tready_i) begin
          sbuff_ctrl_o.read_stall = 1'b1;
          sbuff_ctrl_o.ren        = 1'b0;
        end
        if (ctrl_wdone_i) begin
          state_d = mcu_pkg::st_idle;
        end
      end

      default: state_d = mcu_pkg::st_idle;
    endcase
  end

endmodule

`default_nettype wire

//--- mcu_top.sv
// Memory control unit for the vector load/store path.
// Connects the config decoder and the store and load sequencers to the outside.

`default_nettype none

module mcu_top #(
  parameter integer VLEN        = 8192,
  parameter integer BUFF_RD_LAT = mcu_pkg::BUFF_RD_LAT_DEF
) (
  input  logic                    clk,
  input  logic                    rstn,
  // Scheduler
  input  mcu_pkg::vtype_t         mcu_vtype_i,
  input  logic [31:0]             mcu_vl_i,
  input  logic                    mcu_st_vld_i,
  output logic                    mcu_st_rdy_o,
  input  logic                    mcu_ld_vld_i,
  output logic                    mcu_ld_rdy_o,
  output logic                    mcu_ld_buffered_o,
  // Buffer array configuration
  output logic [$clog2(VLEN)-1:0] cfg_vl_o,
  output mcu_pkg::mem_cfg_t       store_cfg_o,
  output logic                    store_cfg_update_o,
  output logic                    store_cntr_rst_o,
  output mcu_pkg::mem_cfg_t       load_cfg_o,
  output logic                    load_cfg_update_o,
  output logic                    load_cntr_rst_o,
  // Data buffers
  output mcu_pkg::buff_ctrl_t     sbuff_ctrl_o,
  input  mcu_pkg::buff_status_t   sbuff_status_i,
  output mcu_pkg::buff_ctrl_t     ldbuff_ctrl_o,
  output logic                    ldbuff_flush_o,
  input  mcu_pkg::buff_status_t   ldbuff_status_i,
  // Vector lane
  input  logic                    vlane_store_dvalid_i,
  output logic                    vlane_store_rdy_o,
  input  logic                    vlane_load_rdy_i,
  output logic                    vlane_load_dvalid_o,
  output logic                    vlane_load_last_o,
  // Memory master, write side
  output logic                    ctrl_wstart_o,
  input  logic                    ctrl_wdone_i,
  output logic                    wr_tvalid_o,
  input  logic                    wr_tready_i,
  // Memory master, read side
  output logic                    ctrl_rstart_o,
  input  logic                    rd_tvalid_i,
  input  logic                    rd_tlast_i,
  output logic                    rd_tready_o
);

  mcu_pkg::mem_cfg_t dec_cfg;

  assign cfg_vl_o = mcu_vl_i[$clog2(VLEN)-1:0];

  mcu_cfg_decode u_cfg_decode (
    .vtype_i (mcu_vtype_i),
    .cfg_o   (dec_cfg)
  );

  mcu_store_ctrl #(
    .BUFF_RD_LAT (BUFF_RD_LAT)
  ) u_store_ctrl (
    .clk                  (clk),
    .rstn                 (rstn),
    .mcu_st_vld_i         (mcu_st_vld_i),
    .dec_cfg_i            (dec_cfg),
    .mcu_st_rdy_o         (mcu_st_rdy_o),
    .store_cfg_o          (store_cfg_o),
    .store_cfg_update_o   (store_cfg_update_o),
    .store_cntr_rst_o     (store_cntr_rst_o),
    .sbuff_ctrl_o         (sbuff_ctrl_o),
    .sbuff_status_i       (sbuff_status_i),
    .vlane_store_dvalid_i (vlane_store_dvalid_i),
    .vlane_store_rdy_o    (vlane_store_rdy_o),
    .ctrl_wstart_o        (ctrl_wstart_o),
    .ctrl_wdone_i         (ctrl_wdone_i),
    .wr_tready_i          (wr_tready_i),
    .wr_tvalid_o          (wr_tvalid_o)
  );

  mcu_load_ctrl #(
    .BUFF_RD_LAT (BUFF_RD_LAT)
  ) u_load_ctrl (
    .clk                 (clk),
    .rstn                (rstn),
    .mcu_ld_vld_i        (mcu_ld_vld_i),
    .dec_cfg_i           (dec_cfg),
    .mcu_ld_rdy_o        (mcu_ld_rdy_o),
    .mcu_ld_buffered_o   (mcu_ld_buffered_o),
    .load_cfg_o          (load_cfg_o),
    .load_cfg_update_o   (load_cfg_update_o),
    .load_cntr_rst_o     (load_cntr_rst_o),
    .ldbuff_ctrl_o       (ldbuff_ctrl_o),
    .ldbuff_flush_o      (ldbuff_flush_o),
    .ldbuff_status_i     (ldbuff_status_i),
    .ctrl_rstart_o       (ctrl_rstart_o),
    .rd_tvalid_i         (rd_tvalid_i),
    .rd_tlast_i          (rd_tlast_i),
    .rd_tready_o         (rd_tready_o),
    .vlane_load_rdy_i    (vlane_load_rdy_i),
    .vlane_load_dvalid_o (vlane_load_dvalid_o),
    .vlane_load_last_o   (vlane_load_last_o)
  );

endmodule

`default_nettype wire

//--- tb_mcu.sv
// Self-checking testbench for the memory control unit.
// Models the data buffers, memory master and vector lane around mcu_top.

`default_nettype none

module tb_mcu;

  localparam integer NUM_REQ   = 30;
  localparam integer TIMEOUT   = 20000;
  localparam integer VL_BITS   = 13;

  logic                  clk;
  logic                  rstn;
  mcu_pkg::vtype_t       mcu_vtype_i;
  logic [31:0]           mcu_vl_i;
  logic                  mcu_st_vld_i, mcu_st_rdy_o;
  logic                  mcu_ld_vld_i, mcu_ld_rdy_o, mcu_ld_buffered_o;
  logic [VL_BITS-1:0]    cfg_vl_o;
  mcu_pkg::mem_cfg_t     store_cfg_o, load_cfg_o;
  logic                  store_cfg_update_o, store_cntr_rst_o;
  logic                  load_cfg_update_o, load_cntr_rst_o;
  mcu_pkg::buff_ctrl_t   sbuff_ctrl_o, ldbuff_ctrl_o;
  mcu_pkg::buff_status_t sbuff_status_i, ldbuff_status_i;
  logic                  ldbuff_flush_o;
  logic                  vlane_store_dvalid_i, vlane_store_rdy_o;
  logic                  vlane_load_rdy_i, vlane_load_dvalid_o, vlane_load_last_o;
  logic                  ctrl_wstart_o, ctrl_wdone_i, wr_tvalid_o, wr_tready_i;
  logic                  ctrl_rstart_o, rd_tvalid_i, rd_tlast_i, rd_tready_o;

  mcu_top UUT (.*);

  ////////////////////
  // Stimulus helpers
  ////////////////////

  logic [31:0] lfsr = 32'hc516;

  function logic rand_bit();
    logic lsb;
    lsb  = lfsr[0];
    lfsr = lfsr >> 1;
    if (lsb) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return lsb;
  endfunction

  function logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], rand_bit()};
    end
    return val;
  endfunction

  // Data SEW is the width code and data LMUL follows the EMUL rule
  function automatic mcu_pkg::mem_cfg_t ref_emul(input mcu_pkg::vtype_t vt);
    mcu_pkg::mem_cfg_t cfg;
    int                lmul_l2;
    int                res;
    logic              ok;
    ok = 1'b1;
    case (vt.lmul)
      3'd0: lmul_l2 = 0;
      3'd1: lmul_l2 = 1;
      3'd2: lmul_l2 = 2;
      3'd3: lmul_l2 = 3;
      3'd5: lmul_l2 = -3;
      3'd6: lmul_l2 = -2;
      3'd7: lmul_l2 = -1;
      default: begin
        lmul_l2 = 0;
        ok      = 1'b0;
      end
    endcase
    res = lmul_l2 + int'(vt.mem_width[1:0]) - int'(vt.sew[1:0]);
    if (vt.sew == 3'd3 || res < -3 || res > 3) begin
      ok = 1'b0;
    end
    cfg.data_sew  = vt.mem_width;
    cfg.data_lmul = !ok ? 3'd0 : (res < 0) ? 3'(res + 8) : 3'(res);
    return cfg;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at time %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic stop_run(input string why);
    $display("%s at time %0t", why, $time);
    $display("Errors found");
    $fatal(1, "%s", why);
  endtask

  ////////////////////
  // Clock and models
  ////////////////////

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  logic              run = 1'b0;
  mcu_pkg::mem_cfg_t st_exp_q[$], ld_exp_q[$];
  int  st_issued = 0, ld_issued = 0, st_gap = 0, ld_gap = 0;
  int  st_done = 0, ld_done = 0;
  // Store side buffer and memory model
  int  st_wcnt = 0, st_rcnt = 0, st_target = 1, st_quiet = 0, st_wstarts = 0;
  logic st_busy = 1'b0, st_vld_d = 1'b0, st_end_d = 1'b0;
  // Load side buffer and memory model
  int  ld_wcnt = 0, ld_rcnt = 0, ld_sent = 0, ld_beats = 1;
  int  ld_rstarts = 0, ld_bufs = 0, ld_lasts = 0;
  logic ld_active = 1'b0, ld_draining = 1'b0, ld_vld_d = 1'b0, ld_end_d = 1'b0;
  logic ld_last_prev = 1'b0;

  // Inputs change on the falling edge only
  always @(negedge clk) begin
    sbuff_status_i.write_done  = (st_wcnt >= st_target);
    sbuff_status_i.read_done   = (st_rcnt > 0) && (st_rcnt >= st_wcnt);
    sbuff_status_i.not_empty   = (st_wcnt > st_rcnt);
    ldbuff_status_i.write_done = (ld_wcnt > 0);
    ldbuff_status_i.read_done  = (ld_rcnt > 0) && (ld_rcnt >= ld_wcnt);
    ldbuff_status_i.not_empty  = (ld_wcnt > ld_rcnt);
    ctrl_wdone_i = st_busy && (st_quiet >= 3);
    if (run) begin
      vlane_store_dvalid_i = rand_bit();
      wr_tready_i          = (rand_bits(2) != 0);
      vlane_load_rdy_i     = (rand_bits(2) != 0);
      rd_tvalid_i          = ld_active && rand_bit();
      rd_tlast_i           = rd_tvalid_i && (ld_sent == ld_beats - 1);
      mcu_vtype_i.sew       = {1'b0, 2'(rand_bits(2))};
      mcu_vtype_i.lmul      = 3'(rand_bits(3));
      mcu_vtype_i.mem_width = 3'(rand_bits(3));
      mcu_st_vld_i = 1'b0;
      mcu_ld_vld_i = 1'b0;
      if (st_issued < NUM_REQ && st_gap == 0 && mcu_st_rdy_o) begin
        mcu_st_vld_i = 1'b1;
        st_exp_q.push_back(ref_emul(mcu_vtype_i));
        st_issued++;
        st_gap = int'(rand_bits(2));
      end else if (st_gap > 0) begin
        st_gap--;
      end
      if (ld_issued < NUM_REQ && ld_gap == 0 && mcu_ld_rdy_o) begin
        mcu_ld_vld_i = 1'b1;
        ld_exp_q.push_back(ref_emul(mcu_vtype_i));
        ld_issued++;
        ld_gap = int'(rand_bits(2));
      end else if (ld_gap > 0) begin
        ld_gap--;
      end
    end
  end

  ////////////////////
  // Compare process
  ////////////////////

  // Samples settled outputs at the rising edge, before the DUT updates
  always @(posedge clk) begin
    if (rstn) begin
      // Store request and configuration
      check("store_cfg_update_o", 32'(store_cfg_update_o), 32'(st_vld_d));
      check("store_cntr_rst_o", 32'(store_cntr_rst_o), 32'(st_vld_d));
      if (st_vld_d) begin
        check("mcu_st_rdy_o", 32'(mcu_st_rdy_o), 32'd0);
        if (st_exp_q.size() == 0) begin
          stop_run("store configuration seen without a store request");
        end else begin
          check("store_cfg_o", 32'(store_cfg_o), 32'(st_exp_q.pop_front()));
        end
      end
      if (st_end_d) begin
        check("mcu_st_rdy_o", 32'(mcu_st_rdy_o), 32'd1);
      end
      if (vlane_store_rdy_o) begin
        check("sbuff_ctrl_o.wen", 32'(sbuff_ctrl_o.wen), 32'(vlane_store_dvalid_i));
      end
      // Back-pressure only acts while the store buffer drains
      check("sbuff_ctrl_o.read_stall", 32'(sbuff_ctrl_o.read_stall),
            32'(st_busy && !wr_tready_i));
      if (st_busy && !wr_tready_i) begin
        check("sbuff_ctrl_o.ren", 32'(sbuff_ctrl_o.ren), 32'd0);
      end

      // Load request and configuration
      check("load_cfg_update_o", 32'(load_cfg_update_o), 32'(ld_vld_d));
      check("load_cntr_rst_o", 32'(load_cntr_rst_o), 32'(ld_vld_d));
      if (ld_vld_d) begin
        check("mcu_ld_rdy_o", 32'(mcu_ld_rdy_o), 32'd0);
        if (ld_exp_q.size() == 0) begin
          stop_run("load configuration seen without a load request");
        end else begin
          check("load_cfg_o", 32'(load_cfg_o), 32'(ld_exp_q.pop_front()));
        end
      end
      if (ld_end_d) begin
        check("mcu_ld_rdy_o", 32'(mcu_ld_rdy_o), 32'd1);
        check("ctrl_rstart_o pulses", 32'(ld_rstarts), 32'd1);
        check("mcu_ld_buffered_o pulses", 32'(ld_bufs), 32'd1);
        check("vlane_load_last_o pulses", 32'(ld_lasts), 32'd1);
        ld_done++;
      end
      if (rd_tready_o) begin
        check("ldbuff_ctrl_o.wen", 32'(ldbuff_ctrl_o.wen), 32'(rd_tvalid_i));
      end
      check("ldbuff_ctrl_o.read_stall", 32'(ldbuff_ctrl_o.read_stall),
            32'(ld_draining && !vlane_load_rdy_i));
      if (ld_draining && !vlane_load_rdy_i) begin
        check("ldbuff_ctrl_o.ren", 32'(ldbuff_ctrl_o.ren), 32'd0);
      end

      // Store model update
      st_end_d = 1'b0;
      if (store_cntr_rst_o) begin
        st_wcnt    = 0;
        st_rcnt    = 0;
        st_wstarts = 0;
        st_target  = 1 + int'(rand_bits(3));
      end else begin
        st_wcnt += int'(sbuff_ctrl_o.wen);
        st_rcnt += int'(sbuff_ctrl_o.ren);
      end
      if (ctrl_wstart_o) begin
        st_wstarts++;
        st_busy = 1'b1;
      end
      if (ctrl_wdone_i && st_busy) begin
        check("ctrl_wstart_o pulses", 32'(st_wstarts), 32'd1);
        st_busy  = 1'b0;
        st_end_d = 1'b1;
        st_done++;
      end
      if (st_busy && sbuff_status_i.read_done && !wr_tvalid_o) begin
        st_quiet++;
      end else begin
        st_quiet = 0;
      end

      // Load model update
      ld_end_d = 1'b0;
      if (load_cntr_rst_o) begin
        ld_wcnt    = 0;
        ld_rcnt    = 0;
        ld_rstarts = 0;
        ld_bufs    = 0;
        ld_lasts   = 0;
      end else begin
        ld_wcnt += int'(ldbuff_ctrl_o.wen);
        ld_rcnt += int'(ldbuff_ctrl_o.ren);
      end
      if (ctrl_rstart_o) begin
        ld_rstarts++;
        ld_active = 1'b1;
        ld_sent   = 0;
        ld_beats  = 1 + int'(rand_bits(3));
      end
      if (rd_tvalid_i && rd_tready_o) begin
        ld_sent++;
        if (rd_tlast_i) begin
          ld_active = 1'b0;
        end
      end
      if (mcu_ld_buffered_o) begin
        ld_bufs++;
        ld_draining = 1'b1;
      end
      if (vlane_load_last_o && !ld_last_prev) begin
        ld_lasts++;
      end
      if (ld_draining && vlane_load_last_o && vlane_load_rdy_i
          && ldbuff_status_i.read_done) begin
        ld_draining = 1'b0;
        ld_end_d    = 1'b1;
      end
      ld_last_prev = vlane_load_last_o;
      st_vld_d     = mcu_st_vld_i;
      ld_vld_d     = mcu_ld_vld_i;
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int cycles;
    rstn                 = 1'b0;
    mcu_vtype_i          = '0;
    mcu_vl_i             = rand_bits(32);
    mcu_st_vld_i         = 1'b0;
    mcu_ld_vld_i         = 1'b0;
    sbuff_status_i       = '0;
    ldbuff_status_i      = '0;
    vlane_store_dvalid_i = 1'b0;
    vlane_load_rdy_i     = 1'b0;
    ctrl_wdone_i         = 1'b0;
    wr_tready_i          = 1'b0;
    rd_tvalid_i          = 1'b0;
    rd_tlast_i           = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);

    // Idle outputs after reset
    check("mcu_st_rdy_o", 32'(mcu_st_rdy_o), 32'd1);
    check("mcu_ld_rdy_o", 32'(mcu_ld_rdy_o), 32'd1);
    check("mcu_ld_buffered_o", 32'(mcu_ld_buffered_o), 32'd0);
    check("sbuff_ctrl_o", 32'(sbuff_ctrl_o), 32'd0);
    check("ldbuff_ctrl_o", 32'(ldbuff_ctrl_o), 32'd0);
    check("ldbuff_flush_o", 32'(ldbuff_flush_o), 32'd1);
    check("ctrl_wstart_o", 32'(ctrl_wstart_o), 32'd0);
    check("ctrl_rstart_o", 32'(ctrl_rstart_o), 32'd0);
    check("wr_tvalid_o", 32'(wr_tvalid_o), 32'd0);
    check("vlane_load_dvalid_o", 32'(vlane_load_dvalid_o), 32'd0);
    check("vlane_load_last_o", 32'(vlane_load_last_o), 32'd0);
    check("store_cfg_o", 32'(store_cfg_o), 32'd0);
    check("load_cfg_o", 32'(load_cfg_o), 32'd0);
    check("cfg_vl_o", 32'(cfg_vl_o), 32'(mcu_vl_i[VL_BITS-1:0]));
    run = 1'b1;

    // Both paths run overlapped until every request has completed
    cycles = 0;
    while (st_done < NUM_REQ || ld_done < NUM_REQ) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("timeout waiting for requests: %0d stores, %0d loads done",
                 st_done, ld_done);
        $display("Errors found");
        $fatal(1, "timeout");
      end
    end
    run = 1'b0;
    repeat (2) @(negedge clk);
    if (st_exp_q.size() == 0 && ld_exp_q.size() == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("requests left without a configuration update");
      $display("Errors found");
      $fatal(1, "unserved requests");
    end
  end

endmodule

`default_nettype wire
